// ==== rtl/pong_pkg.sv ====
`default_nettype none

package pong_pkg;

    // Global flow, menu through game over
    typedef enum logic [1:0] {
        MENU  = 2'b00,
        RULES = 2'b01,
        PLAY  = 2'b10,
        OVER  = 2'b11
    } glob_state_t;

    // Game flow inside PLAY
    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        RALLY      = 2'b01,
        SERVE_WAIT = 2'b10,
        DONE       = 2'b11
    } game_state_t;

    typedef logic [9:0] coord_t;   // Pixel coordinate
    typedef logic [7:0] score_t;   // Binary score

    // Direction codes for the ball
    localparam logic DIR_LEFT  = 1'b0;
    localparam logic DIR_RIGHT = 1'b1;
    localparam logic DIR_UP    = 1'b0;
    localparam logic DIR_DOWN  = 1'b1;

    localparam score_t SCORE_CAP  = 8'd99;  // Outright win
    localparam score_t WIN_MARGIN = 8'd2;   // Lead needed at the target

endpackage

`default_nettype wire

// ==== rtl/paddle_contact.sv ====
`default_nettype none
`timescale 1ns/1ps

module paddle_contact #(
    parameter int FIELD_W    = 640,
    parameter int BALL_SIZE  = 16,
    parameter int PADDLE_W   = 8,
    parameter int PADDLE_H   = 72,
    parameter int PADDLE_GAP = 1
) (
    input  pong_pkg::coord_t  ball_x,
    input  pong_pkg::coord_t  ball_y,
    input  pong_pkg::coord_t  paddle1_y,
    input  pong_pkg::coord_t  paddle2_y,
    output logic              paddle_hit
);

    // Paddle x never moves
    localparam pong_pkg::coord_t PAD1_X = pong_pkg::coord_t'(PADDLE_GAP);
    localparam pong_pkg::coord_t PAD2_X = pong_pkg::coord_t'(FIELD_W - PADDLE_W - PADDLE_GAP);

    // Open-interval overlap on one axis, one extra bit for the sums
    function automatic logic span_overlap(
        input pong_pkg::coord_t a_lo,
        input int               a_len,
        input pong_pkg::coord_t b_lo,
        input int               b_len
    );
        logic [10:0] a_hi;
        logic [10:0] b_hi;
        a_hi = {1'b0, a_lo} + 11'(a_len);
        b_hi = {1'b0, b_lo} + 11'(b_len);
        return (a_hi > {1'b0, b_lo}) && (b_hi > {1'b0, a_lo});
    endfunction

    logic hit_p1;
    logic hit_p2;

    assign hit_p1 = span_overlap(ball_x, BALL_SIZE, PAD1_X, PADDLE_W)
                 && span_overlap(ball_y, BALL_SIZE, paddle1_y, PADDLE_H);
    assign hit_p2 = span_overlap(ball_x, BALL_SIZE, PAD2_X, PADDLE_W)
                 && span_overlap(ball_y, BALL_SIZE, paddle2_y, PADDLE_H);

    assign paddle_hit = hit_p1 || hit_p2;

endmodule

`default_nettype wire

// ==== rtl/ball_motion.sv ====
`default_nettype none
`timescale 1ns/1ps

module ball_motion #(
    parameter int FIELD_W   = 640,
    parameter int FIELD_H   = 480,
    parameter int BALL_SIZE = 16
) (
    input  wire               tick_ball_x,
    input  wire               reset,
    input  wire               run,
    input  wire               paddle_hit,
    output pong_pkg::coord_t  ball_x,
    output pong_pkg::coord_t  ball_y,
    output logic              out_left,
    output logic              out_right
);

    localparam pong_pkg::coord_t SPAWN_X = pong_pkg::coord_t'(FIELD_W / 2 - BALL_SIZE / 2);
    localparam pong_pkg::coord_t SPAWN_Y = pong_pkg::coord_t'(FIELD_H / 2 - BALL_SIZE / 2);
    localparam pong_pkg::coord_t X_MAX   = pong_pkg::coord_t'(FIELD_W - 1 - BALL_SIZE);
    localparam pong_pkg::coord_t Y_MAX   = pong_pkg::coord_t'(FIELD_H - 1 - BALL_SIZE);

    logic dir_x;        // DIR_LEFT or DIR_RIGHT
    logic dir_y;        // DIR_UP or DIR_DOWN
    logic live;         // Cleared once the ball has left the field
    logic hit_top;
    logic hit_bot;

    // Exit strobes only fire for a live ball in a rally
    assign out_left  = run && live && (ball_x == '0);
    assign out_right = run && live && (ball_x >= X_MAX);

    assign hit_top = (ball_y == '0);
    assign hit_bot = (ball_y >= Y_MAX);

    always_ff @(posedge tick_ball_x or posedge reset) begin
        if (reset) begin
            ball_x <= SPAWN_X;
            ball_y <= SPAWN_Y;
            dir_x  <= pong_pkg::DIR_LEFT;
            dir_y  <= pong_pkg::DIR_UP;
            live   <= 1'b1;
        end else if (!run) begin
            // Respawn between rallies
            ball_x <= SPAWN_X;
            ball_y <= SPAWN_Y;
            dir_x  <= pong_pkg::DIR_LEFT;
            dir_y  <= pong_pkg::DIR_UP;
            live   <= 1'b1;
        end else if (live) begin
            if (out_left || out_right) begin
                live <= 1'b0;   // Freeze until run drops
            end else begin
                if (paddle_hit) begin
                    dir_x  <= ~dir_x;
                    ball_x <= (dir_x == pong_pkg::DIR_LEFT) ? ball_x + 10'd1 : ball_x - 10'd1;
                end else begin
                    ball_x <= (dir_x == pong_pkg::DIR_LEFT) ? ball_x - 10'd1 : ball_x + 10'd1;
                end

                // Top and bottom walls bounce
                if (hit_top || hit_bot) begin
                    dir_y  <= ~dir_y;
                    ball_y <= (dir_y == pong_pkg::DIR_UP) ? ball_y + 10'd1 : ball_y - 10'd1;
                end else begin
                    ball_y <= (dir_y == pong_pkg::DIR_UP) ? ball_y - 10'd1 : ball_y + 10'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/paddle_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module paddle_bank #(
    parameter int FIELD_H  = 480,
    parameter int PADDLE_H = 72
) (
    input  wire               tick_ball_x,
    input  wire               reset,
    input  wire               run,
    input  wire               p1_up,
    input  wire               p1_down,
    input  wire               p2_up,
    input  wire               p2_down,
    output pong_pkg::coord_t  paddle1_y,
    output pong_pkg::coord_t  paddle2_y
);

    localparam pong_pkg::coord_t CENTER_Y = pong_pkg::coord_t'(FIELD_H / 2 - PADDLE_H / 2);
    localparam pong_pkg::coord_t Y_MAX    = pong_pkg::coord_t'(FIELD_H - 1 - PADDLE_H);

    logic             key_up   [2];
    logic             key_down [2];
    pong_pkg::coord_t pad_y    [2];

    // Index 0 is the left paddle
    assign key_up[0]   = p1_up;
    assign key_down[0] = p1_down;
    assign key_up[1]   = p2_up;
    assign key_down[1] = p2_down;

    for (genvar i = 0; i < 2; i++) begin : g_paddle
        always_ff @(posedge tick_ball_x or posedge reset) begin
            if (reset) begin
                pad_y[i] <= CENTER_Y;
            end else if (!run) begin
                pad_y[i] <= CENTER_Y;   // Hold at center outside a rally
            end else begin
                case ({key_up[i], key_down[i]})
                    2'b10: begin
                        if (pad_y[i] != '0)
                            pad_y[i] <= pad_y[i] - 10'd1;
                    end
                    2'b01: begin
                        if (pad_y[i] < Y_MAX)
                            pad_y[i] <= pad_y[i] + 10'd1;
                    end
                    default: begin
                        pad_y[i] <= pad_y[i];   // None or both held
                    end
                endcase
            end
        end
    end

    assign paddle1_y = pad_y[0];
    assign paddle2_y = pad_y[1];

endmodule

`default_nettype wire

// ==== rtl/match_control.sv ====
`default_nettype none
`timescale 1ns/1ps

module match_control #(
    parameter int FIELD_W    = 640,
    parameter int BALL_SIZE  = 16,
    parameter int PADDLE_W   = 8,
    parameter int PADDLE_H   = 72,
    parameter int PADDLE_GAP = 1
) (
    input  wire                    tick_ball_x,
    input  wire                    reset,
    input  wire                    start,
    input  pong_pkg::score_t       max_score,
    input  pong_pkg::coord_t       ball_x,
    input  pong_pkg::coord_t       ball_y,
    input  pong_pkg::coord_t       paddle1_y,
    input  pong_pkg::coord_t       paddle2_y,
    input  wire                    out_left,
    input  wire                    out_right,
    output logic                   run,
    output logic                   paddle_hit,
    output pong_pkg::glob_state_t  glob_state,
    output pong_pkg::game_state_t  game_state,
    output pong_pkg::score_t       score_p1,
    output pong_pkg::score_t       score_p2
);

    pong_pkg::glob_state_t glob_next;
    pong_pkg::game_state_t game_next;
    pong_pkg::score_t      score_diff;
    logic                  win;
    logic                  exit_seen;   // Ball left the field on the last edge

    paddle_contact #(
        .FIELD_W    (FIELD_W),
        .BALL_SIZE  (BALL_SIZE),
        .PADDLE_W   (PADDLE_W),
        .PADDLE_H   (PADDLE_H),
        .PADDLE_GAP (PADDLE_GAP)
    ) u_contact (
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .paddle1_y  (paddle1_y),
        .paddle2_y  (paddle2_y),
        .paddle_hit (paddle_hit)
    );

    assign run = (game_state == pong_pkg::RALLY);

    assign score_diff = (score_p1 >= score_p2) ? score_p1 - score_p2 : score_p2 - score_p1;

    // Hard cap, or target reached with a two point lead
    assign win = (score_p1 >= pong_pkg::SCORE_CAP) || (score_p2 >= pong_pkg::SCORE_CAP)
              || (((score_p1 >= max_score) || (score_p2 >= max_score))
                  && (score_diff >= pong_pkg::WIN_MARGIN));

    always_comb begin
        glob_next = glob_state;
        case (glob_state)
            pong_pkg::MENU:  if (start) glob_next = pong_pkg::RULES;
            pong_pkg::RULES: if (start) glob_next = pong_pkg::PLAY;
            pong_pkg::PLAY:  if (game_state == pong_pkg::DONE) glob_next = pong_pkg::OVER;
            pong_pkg::OVER:  if (start) glob_next = pong_pkg::MENU;
            default:         glob_next = pong_pkg::MENU;
        endcase
    end

    always_comb begin
        game_next = game_state;
        case (game_state)
            pong_pkg::IDLE: begin
                if (glob_state == pong_pkg::PLAY)
                    game_next = pong_pkg::SERVE_WAIT;
            end
            pong_pkg::SERVE_WAIT: begin
                if (start)
                    game_next = pong_pkg::RALLY;
            end
            pong_pkg::RALLY: begin
                // Scores already updated when exit_seen is set
                if (exit_seen)
                    game_next = win ? pong_pkg::DONE : pong_pkg::SERVE_WAIT;
            end
            pong_pkg::DONE: game_next = pong_pkg::IDLE;
            default:        game_next = pong_pkg::IDLE;
        endcase
    end

    always_ff @(posedge tick_ball_x or posedge reset) begin
        if (reset) begin
            glob_state <= pong_pkg::MENU;
            game_state <= pong_pkg::IDLE;
            exit_seen  <= 1'b0;
        end else begin
            glob_state <= glob_next;
            game_state <= game_next;
            exit_seen  <= out_left || out_right;
        end
    end

    // Scoring on the exit edge
    always_ff @(posedge tick_ball_x or posedge reset) begin
        if (reset) begin
            score_p1 <= '0;
            score_p2 <= '0;
        end else if (glob_state == pong_pkg::MENU) begin
            score_p1 <= '0;
            score_p2 <= '0;
        end else if (out_left) begin
            score_p2 <= score_p2 + 8'd1;   // Left wall is a point for player 2
        end else if (out_right) begin
            score_p1 <= score_p1 + 8'd1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pong_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module pong_top #(
    parameter int FIELD_W    = 640,
    parameter int FIELD_H    = 480,
    parameter int BALL_SIZE  = 16,
    parameter int PADDLE_W   = 8,
    parameter int PADDLE_H   = 72,
    parameter int PADDLE_GAP = 1
) (
    input  wire                    tick_ball_x,
    input  wire                    reset,
    input  wire                    start,
    input  wire                    p1_up,
    input  wire                    p1_down,
    input  wire                    p2_up,
    input  wire                    p2_down,
    input  pong_pkg::score_t       max_score,
    output pong_pkg::glob_state_t  glob_state,
    output pong_pkg::game_state_t  game_state,
    output pong_pkg::score_t       score_p1,
    output pong_pkg::score_t       score_p2,
    output pong_pkg::coord_t       ball_x,
    output pong_pkg::coord_t       ball_y,
    output pong_pkg::coord_t       paddle1_y,
    output pong_pkg::coord_t       paddle2_y
);

    logic run;          // High only in RALLY
    logic paddle_hit;
    logic out_left;
    logic out_right;

    ball_motion #(
        .FIELD_W    (FIELD_W),
        .FIELD_H    (FIELD_H),
        .BALL_SIZE  (BALL_SIZE)
    ) u_ball (
        .tick_ball_x (tick_ball_x),
        .reset       (reset),
        .run         (run),
        .paddle_hit  (paddle_hit),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .out_left    (out_left),
        .out_right   (out_right)
    );

    paddle_bank #(
        .FIELD_H    (FIELD_H),
        .PADDLE_H   (PADDLE_H)
    ) u_paddles (
        .tick_ball_x (tick_ball_x),
        .reset       (reset),
        .run         (run),
        .p1_up       (p1_up),
        .p1_down     (p1_down),
        .p2_up       (p2_up),
        .p2_down     (p2_down),
        .paddle1_y   (paddle1_y),
        .paddle2_y   (paddle2_y)
    );

    match_control #(
        .FIELD_W    (FIELD_W),
        .BALL_SIZE  (BALL_SIZE),
        .PADDLE_W   (PADDLE_W),
        .PADDLE_H   (PADDLE_H),
        .PADDLE_GAP (PADDLE_GAP)
    ) u_match (
        .tick_ball_x (tick_ball_x),
        .reset       (reset),
        .start       (start),
        .max_score   (max_score),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .paddle1_y   (paddle1_y),
        .paddle2_y   (paddle2_y),
        .out_left    (out_left),
        .out_right   (out_right),
        .run         (run),
        .paddle_hit  (paddle_hit),
        .glob_state  (glob_state),
        .game_state  (game_state),
        .score_p1    (score_p1),
        .score_p2    (score_p2)
    );

endmodule

`default_nettype wire

// ==== dv/pong_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module pong_chk #(
    parameter int FIELD_H   = 480,
    parameter int BALL_SIZE = 16
) (
    input wire                    tick_ball_x,
    input wire                    reset,
    input wire                    run,
    input pong_pkg::glob_state_t  glob_state,
    input pong_pkg::score_t       score_p1,
    input pong_pkg::score_t       score_p2,
    input pong_pkg::coord_t       ball_y
);

    // A rally only exists inside PLAY
    rally_in_play: assert property (
        @(posedge tick_ball_x) disable iff (reset)
        run |-> glob_state == pong_pkg::PLAY
    ) else $error("rally running outside PLAY");

    // Only the clear in MENU moves both scores at once
    single_score: assert property (
        @(posedge tick_ball_x) disable iff (reset)
        (score_p1 != $past(score_p1)) && (score_p2 != $past(score_p2))
            |-> $past(glob_state) == pong_pkg::MENU
    ) else $error("both scores changed on one edge");

    ball_in_field: assert property (
        @(posedge tick_ball_x) disable iff (reset)
        run |-> int'(ball_y) + BALL_SIZE <= FIELD_H - 1
    ) else $error("ball_y %0d outside the field", ball_y);

endmodule

bind pong_top pong_chk #(
    .FIELD_H   (FIELD_H),
    .BALL_SIZE (BALL_SIZE)
) u_chk (
    .tick_ball_x (tick_ball_x),
    .reset       (reset),
    .run         (run),
    .glob_state  (glob_state),
    .score_p1    (score_p1),
    .score_p2    (score_p2),
    .ball_y      (ball_y)
);

`default_nettype wire

// ==== dv/pong_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module pong_tb;

    localparam int FIELD_W       = 640;
    localparam int FIELD_H       = 480;
    localparam int BALL_SIZE     = 16;
    localparam int PADDLE_W      = 8;
    localparam int PADDLE_H      = 72;
    localparam int PADDLE_GAP    = 1;
    localparam int SPAWN_X       = FIELD_W / 2 - BALL_SIZE / 2;
    localparam int SPAWN_Y       = FIELD_H / 2 - BALL_SIZE / 2;
    localparam int CENTER_Y      = FIELD_H / 2 - PADDLE_H / 2;
    localparam int PAD_MAX       = FIELD_H - 1 - PADDLE_H;
    localparam int PAD2_X        = FIELD_W - PADDLE_W - PADDLE_GAP;
    localparam int RALLY_LIMIT   = 1200;   // One return takes about 920 cycles
    localparam int RANDOM_CYCLES = 3000;
    localparam int MAX_CYCLES    = 6 * RALLY_LIMIT + RANDOM_CYCLES + 200;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       dx;     // 1 moves right
        logic       dy;     // 1 moves down
        logic       live;
    } ball_t;

    logic                  tick_ball_x;
    logic                  reset;
    logic                  start;
    logic                  p1_up;
    logic                  p1_down;
    logic                  p2_up;
    logic                  p2_down;
    pong_pkg::score_t      max_score;
    pong_pkg::glob_state_t glob_state;
    pong_pkg::game_state_t game_state;
    pong_pkg::score_t      score_p1;
    pong_pkg::score_t      score_p2;
    pong_pkg::coord_t      ball_x;
    pong_pkg::coord_t      ball_y;
    pong_pkg::coord_t      paddle1_y;
    pong_pkg::coord_t      paddle2_y;

    ball_t ref_ball;
    int    ref_p1;
    int    ref_p2;
    int    exp_p1;
    int    exp_p2;
    logic  run_now;
    int    cmp_errors = 0;
    int    seq_errors = 0;
    int    cycles = 0;

    pong_top #(
        .FIELD_W    (FIELD_W),
        .FIELD_H    (FIELD_H),
        .BALL_SIZE  (BALL_SIZE),
        .PADDLE_W   (PADDLE_W),
        .PADDLE_H   (PADDLE_H),
        .PADDLE_GAP (PADDLE_GAP)
    ) DUT (.*);

    initial begin
        tick_ball_x = 1'b0;
        forever #5 tick_ball_x = ~tick_ball_x;
    end

    task automatic check_val(input string name, input int exp, input int got, inout int count);
        assert (exp == got) else begin
            $display("ERR %s exp %h got %h", name, exp, got);
            count++;
        end
    endtask

    function automatic ball_t spawn_ball();
        ball_t s;
        s.x    = 10'(SPAWN_X);
        s.y    = 10'(SPAWN_Y);
        s.dx   = 1'b0;      // Left and up
        s.dy   = 1'b0;
        s.live = 1'b1;
        return s;
    endfunction

    // Strict overlap of the ball square with a paddle
    function automatic bit touches(input int bx, input int by, input int px, input int py);
        return (bx < px + PADDLE_W) && (px < bx + BALL_SIZE)
            && (by < py + PADDLE_H) && (py < by + BALL_SIZE);
    endfunction

    function automatic bit leaves(input ball_t b);
        return (b.x == 10'd0) || (int'(b.x) + BALL_SIZE >= FIELD_W - 1);
    endfunction

    function automatic ball_t ball_next(input ball_t b, input logic run_i,
                                        input int p1y, input int p2y);
        ball_t n;
        bit    hit;
        n = b;
        if (!run_i) begin
            n = spawn_ball();
        end else if (b.live && leaves(b)) begin
            n.live = 1'b0;      // Frozen until the rally ends
        end else if (b.live) begin
            hit = touches(int'(b.x), int'(b.y), PADDLE_GAP, p1y)
               || touches(int'(b.x), int'(b.y), PAD2_X, p2y);
            if (hit)
                n.dx = ~b.dx;
            n.x = n.dx ? b.x + 10'd1 : b.x - 10'd1;
            if (b.y == 10'd0 || int'(b.y) + BALL_SIZE >= FIELD_H - 1)
                n.dy = ~b.dy;
            n.y = n.dy ? b.y + 10'd1 : b.y - 10'd1;
        end
        return n;
    endfunction

    function automatic int paddle_next(input int y, input logic up, input logic down,
                                       input logic run_i);
        if (!run_i)
            return CENTER_Y;
        if (up && !down && y > 0)
            return y - 1;
        if (down && !up && y < PAD_MAX)
            return y + 1;
        return y;
    endfunction

    function automatic bit win_rule(input int a, input int b);
        int lead;
        lead = (a > b) ? a - b : b - a;
        return (a >= int'(pong_pkg::SCORE_CAP)) || (b >= int'(pong_pkg::SCORE_CAP))
            || (((a >= int'(max_score)) || (b >= int'(max_score)))
                && (lead >= int'(pong_pkg::WIN_MARGIN)));
    endfunction

    // Outputs settle after the rising edge, inputs only change 1 ns after it
    always @(negedge tick_ball_x) begin
        if (reset) begin
            ref_ball = spawn_ball();
            ref_p1   = CENTER_Y;
            ref_p2   = CENTER_Y;
            exp_p1   = 0;
            exp_p2   = 0;
        end else begin
            check_val("ball_x", int'(ref_ball.x), int'(ball_x), cmp_errors);
            check_val("ball_y", int'(ref_ball.y), int'(ball_y), cmp_errors);
            check_val("paddle1_y", ref_p1, int'(paddle1_y), cmp_errors);
            check_val("paddle2_y", ref_p2, int'(paddle2_y), cmp_errors);
            check_val("score_p1", exp_p1, int'(score_p1), cmp_errors);
            check_val("score_p2", exp_p2, int'(score_p2), cmp_errors);
            run_now = (game_state == pong_pkg::RALLY);
            if (glob_state == pong_pkg::MENU) begin
                exp_p1 = 0;
                exp_p2 = 0;
            end else if (run_now && ref_ball.live && leaves(ref_ball)) begin
                if (ref_ball.x == 10'd0)
                    exp_p2++;   // Left wall
                else
                    exp_p1++;
            end
            ref_ball = ball_next(ref_ball, run_now, ref_p1, ref_p2);
            ref_p1   = paddle_next(ref_p1, p1_up, p1_down, run_now);
            ref_p2   = paddle_next(ref_p2, p2_up, p2_down, run_now);
        end
    end

    always @(posedge tick_ball_x) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout, the run went past %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic pulse_start();
        start = 1'b1;
        @(posedge tick_ball_x);
        #1 start = 1'b0;
    endtask

    task automatic wait_rally_end();
        int n;
        int want;
        n = 0;
        while (game_state == pong_pkg::RALLY && n < RALLY_LIMIT) begin
            @(posedge tick_ball_x);
            #1;
            n++;
        end
        assert (game_state != pong_pkg::RALLY) else begin
            $display("rally still running after %0d cycles", RALLY_LIMIT);
            seq_errors++;
        end
        want = win_rule(exp_p1, exp_p2) ? int'(pong_pkg::DONE) : int'(pong_pkg::SERVE_WAIT);
        check_val("game_state", want, int'(game_state), seq_errors);
    endtask

    // Left paddle moves up to return the serve, right paddle drops out of the way
    // Without a return the right paddle climbs into its top stop
    task automatic serve_rally(input bit deflect);
        p1_up   = deflect;
        p2_down = deflect;
        p2_up   = !deflect;
        pulse_start();
        check_val("game_state", int'(pong_pkg::RALLY), int'(game_state), seq_errors);
        if (deflect) begin
            repeat (150) @(posedge tick_ball_x);
            #1 p1_up = 1'b0;
        end
        wait_rally_end();
        p2_down = 1'b0;
        p2_up   = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h1259));
        reset     = 1'b1;
        start     = 1'b0;
        p1_up     = 1'b0;
        p1_down   = 1'b0;
        p2_up     = 1'b0;
        p2_down   = 1'b0;
        max_score = 8'd3;
        repeat (3) @(posedge tick_ball_x);
        #1 reset = 1'b0;

        check_val("glob_state", int'(pong_pkg::MENU), int'(glob_state), seq_errors);
        check_val("game_state", int'(pong_pkg::IDLE), int'(game_state), seq_errors);
        pulse_start();
        check_val("glob_state", int'(pong_pkg::RULES), int'(glob_state), seq_errors);
        pulse_start();
        check_val("glob_state", int'(pong_pkg::PLAY), int'(glob_state), seq_errors);
        check_val("game_state", int'(pong_pkg::IDLE), int'(game_state), seq_errors);
        @(posedge tick_ball_x);
        #1;
        check_val("game_state", int'(pong_pkg::SERVE_WAIT), int'(game_state), seq_errors);

        // Points go 0-1, 0-2, 1-2, 2-2, 2-3, 2-4 and only the last one wins
        for (int i = 0; i < 6; i++)
            serve_rally(i == 2 || i == 3);
        @(posedge tick_ball_x);
        #1;
        check_val("glob_state", int'(pong_pkg::OVER), int'(glob_state), seq_errors);
        check_val("game_state", int'(pong_pkg::IDLE), int'(game_state), seq_errors);
        pulse_start();
        check_val("glob_state", int'(pong_pkg::MENU), int'(glob_state), seq_errors);
        @(posedge tick_ball_x);
        #1;
        check_val("score_p1", 0, int'(score_p1), seq_errors);
        check_val("score_p2", 0, int'(score_p2), seq_errors);

        // Free play, keys held for random stretches
        max_score = 8'd40;
        pulse_start();
        pulse_start();
        repeat (RANDOM_CYCLES) begin
            @(posedge tick_ball_x);
            #1;
            if ($urandom_range(15) == 0)
                {p1_up, p1_down, p2_up, p2_down} = 4'($urandom_range(15));
            start = (game_state == pong_pkg::SERVE_WAIT);   // Serve again at once
        end

        $display("errors: %0d per cycle, %0d in sequence", cmp_errors, seq_errors);
        if (cmp_errors + seq_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/pong_pkg.sv
rtl/paddle_contact.sv
rtl/ball_motion.sv
rtl/paddle_bank.sv
rtl/match_control.sv
rtl/pong_top.sv
dv/pong_chk.sv
dv/pong_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pong_tb -f build.f -o pong_sim \
    && ./obj_dir/pong_sim | tee /dev/stderr | grep -x "sim passed" > /dev/null \
    && { echo "run ok"; exit 0; } \
    || { echo "run failed"; exit 1; }
